/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module sbit_align_tb -f verilog.f \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vsbit_align_tb > sim.log 2>&1
cat sim.log
grep -q -F '*** TEST FAILED ***' sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q -F '*** TEST PASSED ***' sim.log || { echo "Simulation ended without a pass"; exit 1; }
exit 0

/* src/align_apb_regs.sv */
`timescale 1ns/1ps
// Aligner register block: APB slave for channel mask, ready threshold, soft reset and status
module align_apb_regs (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      psel,
  input  logic                                      penable,
  input  logic                                      pwrite,
  input  logic [sbit_align_pkg::APB_ADDR_WIDTH-1:0] paddr,
  input  logic [sbit_align_pkg::APB_DATA_WIDTH-1:0] pwdata,
  output logic [sbit_align_pkg::APB_DATA_WIDTH-1:0] prdata,
  output logic                                      pready,
  output logic                                      pslverr,
  input  logic [sbit_align_pkg::NUM_CHANNELS-1:0]   aligned,
  input  logic [sbit_align_pkg::NUM_CHANNELS-1:0]   unstable,
  output logic [sbit_align_pkg::NUM_CHANNELS-1:0]   channel_mask,
  output logic [sbit_align_pkg::COUNT_WIDTH-1:0]    ready_count,
  output logic                                      soft_reset
);

  import sbit_align_pkg::*;

  logic access;
  logic write_en;
  logic hit_ctrl;
  logic hit_ready_count;
  logic hit_status;
  logic mapped;

  // ------------------------------
  // Access decode
  // ------------------------------

  // Zero wait states, every access phase completes
  assign pready = 1'b1;

  assign access   = psel & penable;
  assign write_en = access & pwrite;

  assign hit_ctrl        = (paddr == ADDR_CTRL);
  assign hit_ready_count = (paddr == ADDR_READY_COUNT);
  assign hit_status      = (paddr == ADDR_STATUS);
  assign mapped          = hit_ctrl | hit_ready_count | hit_status;

  // Unmapped address, or a write to the read-only status
  assign pslverr = access & (~mapped | (pwrite & hit_status));

  // ------------------------------
  // Writable registers
  // ------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      channel_mask <= '0;
      ready_count  <= READY_COUNT_RESET;
    end else if (write_en) begin
      if (hit_ctrl) begin
        channel_mask <= pwdata[NUM_CHANNELS-1:0];
      end
      if (hit_ready_count) begin
        ready_count <= pwdata[COUNT_WIDTH-1:0];
      end
    end
  end

  // Self-clearing, high for the cycle after the write
  always_ff @(posedge clock) begin
    if (reset) begin
      soft_reset <= 1'b0;
    end else begin
      soft_reset <= write_en & hit_ctrl & pwdata[SOFT_RESET_BIT];
    end
  end

  // ------------------------------
  // Read mux
  // ------------------------------

  // Valid in the access phase
  // Soft reset bit always reads zero
  always_comb begin
    prdata = '0;
    if (hit_ctrl) begin
      prdata[NUM_CHANNELS-1:0] = channel_mask;
    end else if (hit_ready_count) begin
      prdata[COUNT_WIDTH-1:0] = ready_count;
    end else if (hit_status) begin
      prdata[NUM_CHANNELS-1:0]            = aligned;
      prdata[UNSTABLE_LSB +: NUM_CHANNELS] = unstable;
    end
  end

endmodule

/* src/frame_aligner.sv */
`timescale 1ns/1ps
// Frame aligner: decodes the SoF phase, slips all lanes and tracks alignment for one channel
module frame_aligner (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   soft_reset,
  input  logic                                   mask,
  input  logic [sbit_align_pkg::COUNT_WIDTH-1:0] ready_count,
  input  logic [sbit_align_pkg::MXSBITS-1:0]     sbits_in,
  input  logic [sbit_align_pkg::FRAME_SIZE-1:0]  start_of_frame,
  output logic [sbit_align_pkg::MXSBITS-1:0]     sbits_out,
  output logic                                   sot_is_aligned,
  output logic                                   sot_unstable
);

  import sbit_align_pkg::*;

  // Hardware or register soft reset
  logic                   chan_reset;
  // Data lanes run only when enabled and aligned
  logic                   lane_reset;
  logic [FRAME_SIZE-1:0]  sof_reg;
  logic [SLIP_WIDTH-1:0]  slip_next;
  logic                   good_next;
  logic [SLIP_WIDTH-1:0]  slip_count;
  logic                   sof_good;
  logic [FRAME_SIZE-1:0]  sof_slipped;
  logic                   sof_locked;
  logic [COUNT_WIDTH-1:0] stable_count;

  assign chan_reset = reset | soft_reset;
  assign lane_reset = chan_reset | mask | ~sot_is_aligned;

  // ------------------------------
  // SoF capture and decode
  // ------------------------------

  // Edge 1, raw SoF sample
  always_ff @(posedge clock) begin
    sof_reg <= start_of_frame;
  end

  // One-hot at bit p gives slip (p+1) mod 8
  // Anything else falls back to slip 1 and is flagged bad
  always_comb begin
    slip_next = SLIP_WIDTH'(1);
    good_next = 1'b0;
    for (int p = 0; p < FRAME_SIZE; p++) begin
      if (sof_reg == (FRAME_SIZE'(1) << p)) begin
        slip_next = SLIP_WIDTH'(p + 1);
        good_next = 1'b1;
      end
    end
  end

  // Edge 2, slip count and good flag
  always_ff @(posedge clock) begin
    if (chan_reset) begin
      slip_count <= SLIP_WIDTH'(1);
      sof_good   <= 1'b0;
    end else begin
      slip_count <= slip_next;
      sof_good   <= good_next;
    end
  end

  // ------------------------------
  // Lane slips
  // ------------------------------

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    frame_bitslip u_data_slip (
      .clock      (clock),
      .reset      (lane_reset),
      .slip_count (slip_count),
      .din        (sbits_in[i*FRAME_SIZE +: FRAME_SIZE]),
      .dout       (sbits_out[i*FRAME_SIZE +: FRAME_SIZE])
    );
  end

  // Monitor lane, SoF slipped by its own count
  frame_bitslip u_sof_slip (
    .clock      (clock),
    .reset      (chan_reset),
    .slip_count (slip_count),
    .din        (sof_reg),
    .dout       (sof_slipped)
  );

  // Correct slip lands the SoF on the top bit only
  assign sof_locked = sof_slipped[FRAME_SIZE-1] & ~|sof_slipped[FRAME_SIZE-2:0];

  // ------------------------------
  // Stability and flags
  // ------------------------------

  // Edge 3, saturating count of good SoF cycles
  always_ff @(posedge clock) begin
    if (chan_reset) begin
      stable_count <= '0;
    end else if (!sof_good) begin
      stable_count <= '0;
    end else if (stable_count >= ready_count) begin
      // Also pulls the count down if the threshold was lowered
      stable_count <= ready_count;
    end else begin
      stable_count <= stable_count + 1'b1;
    end
  end

  // Edge 4, aligned once the threshold is reached
  always_ff @(posedge clock) begin
    if (chan_reset) begin
      sot_is_aligned <= 1'b0;
    end else begin
      sot_is_aligned <= (stable_count == ready_count) & sof_locked;
    end
  end

  // Sticky, bad SoF while aligned
  always_ff @(posedge clock) begin
    if (chan_reset) begin
      sot_unstable <= 1'b0;
    end else if (sot_is_aligned && !sof_good) begin
      sot_unstable <= 1'b1;
    end
  end

endmodule

/* src/frame_bitslip.sv */
`timescale 1ns/1ps
// Frame bitslip: registered 8-bit window taken across the previous and current frame
module frame_bitslip (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic [sbit_align_pkg::SLIP_WIDTH-1:0] slip_count,
  input  logic [sbit_align_pkg::FRAME_SIZE-1:0] din,
  output logic [sbit_align_pkg::FRAME_SIZE-1:0] dout
);

  import sbit_align_pkg::*;

  // ------------------------------
  // Frame history
  // ------------------------------

  // Frame seen on the previous clock
  logic [FRAME_SIZE-1:0]   din_prev;
  // Current frame on top, previous below
  logic [2*FRAME_SIZE-1:0] window;

  assign window = {din, din_prev};

  // ------------------------------
  // Slip register
  // ------------------------------

  // Slip of n takes bits [n+7:n]
  // n = 0 gives the previous frame unchanged
  // Larger n pulls in low bits of the current frame
  always_ff @(posedge clock) begin
    if (reset) begin
      // History cleared too, so the first frame after reset
      // is padded with zeros from below
      din_prev <= '0;
      dout     <= '0;
    end else begin
      din_prev <= din;
      dout     <= window[slip_count +: FRAME_SIZE];
    end
  end

endmodule

/* src/sbit_align_pkg.sv */
// S-bit aligner shared constants: channel geometry, APB widths and register map
package sbit_align_pkg;

  // ------------------------------
  // Channel geometry
  // ------------------------------

  // Input channels on the board
  localparam int NUM_CHANNELS = 4;
  // Bits per lane per frame clock
  localparam int FRAME_SIZE   = 8;
  // Byte lanes per channel
  localparam int LANES        = 8;
  // Trigger bits per channel per frame
  localparam int MXSBITS      = LANES * FRAME_SIZE;
  // Slip count selects one of FRAME_SIZE windows
  localparam int SLIP_WIDTH   = $clog2(FRAME_SIZE);
  // Stable-cycle threshold width
  localparam int COUNT_WIDTH  = 12;

  // ------------------------------
  // APB register map
  // ------------------------------

  localparam int APB_ADDR_WIDTH = 8;
  localparam int APB_DATA_WIDTH = 32;

  localparam logic [APB_ADDR_WIDTH-1:0] ADDR_CTRL        = 8'h00;
  localparam logic [APB_ADDR_WIDTH-1:0] ADDR_READY_COUNT = 8'h04;
  localparam logic [APB_ADDR_WIDTH-1:0] ADDR_STATUS      = 8'h08;

  // CTRL bit 8, write one for a single-cycle soft reset
  localparam int SOFT_RESET_BIT = 8;
  // STATUS field holding the unstable flags
  localparam int UNSTABLE_LSB   = 8;

  // Threshold after power-up
  localparam logic [COUNT_WIDTH-1:0] READY_COUNT_RESET = 12'd16;

endpackage

/* src/sbit_align_top.sv */
`timescale 1ns/1ps
// S-bit input front end: APB register block driving four per-channel frame aligners
module sbit_align_top (
  input  logic                                                            clock,
  input  logic                                                            reset,
  input  logic                                                            psel,
  input  logic                                                            penable,
  input  logic                                                            pwrite,
  input  logic [sbit_align_pkg::APB_ADDR_WIDTH-1:0]                       paddr,
  input  logic [sbit_align_pkg::APB_DATA_WIDTH-1:0]                       pwdata,
  output logic [sbit_align_pkg::APB_DATA_WIDTH-1:0]                       prdata,
  output logic                                                            pready,
  output logic                                                            pslverr,
  input  logic [sbit_align_pkg::NUM_CHANNELS*sbit_align_pkg::MXSBITS-1:0] sbits_in,
  input  logic [sbit_align_pkg::NUM_CHANNELS*sbit_align_pkg::FRAME_SIZE-1:0]
                                                                          start_of_frame,
  output logic [sbit_align_pkg::NUM_CHANNELS*sbit_align_pkg::MXSBITS-1:0] sbits_out,
  output logic [sbit_align_pkg::NUM_CHANNELS-1:0]                         aligned
);

  import sbit_align_pkg::*;

  // Register block outputs, shared by every channel
  logic [NUM_CHANNELS-1:0] channel_mask;
  logic [COUNT_WIDTH-1:0]  ready_count;
  logic                    soft_reset;
  // Sticky per-channel flags back to STATUS
  logic [NUM_CHANNELS-1:0] unstable;

  // ------------------------------
  // Register block
  // ------------------------------

  align_apb_regs u_regs (
    .clock        (clock),
    .reset        (reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .aligned      (aligned),
    .unstable     (unstable),
    .channel_mask (channel_mask),
    .ready_count  (ready_count),
    .soft_reset   (soft_reset)
  );

  // ------------------------------
  // Channel aligners
  // ------------------------------

  // Channel c owns slice c of each wide bus
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
    frame_aligner u_aligner (
      .clock          (clock),
      .reset          (reset),
      .soft_reset     (soft_reset),
      .mask           (channel_mask[c]),
      .ready_count    (ready_count),
      .sbits_in       (sbits_in[c*MXSBITS +: MXSBITS]),
      .start_of_frame (start_of_frame[c*FRAME_SIZE +: FRAME_SIZE]),
      .sbits_out      (sbits_out[c*MXSBITS +: MXSBITS]),
      .sot_is_aligned (aligned[c]),
      .sot_unstable   (unstable[c])
    );
  end

endmodule

/* testbench/sbit_align_props.sv */
// S-bit aligner properties: APB response rules and alignment flag behavior
`timescale 1ns/1ps
module sbit_align_props (
  input logic                                                            clock,
  input logic                                                            reset,
  input logic                                                            psel,
  input logic                                                            penable,
  input logic                                                            pready,
  input logic                                                            pslverr,
  input logic [sbit_align_pkg::NUM_CHANNELS-1:0]                         aligned,
  input logic [sbit_align_pkg::NUM_CHANNELS-1:0]                         unstable,
  input logic [sbit_align_pkg::NUM_CHANNELS*sbit_align_pkg::MXSBITS-1:0] sbits_out
);

  import sbit_align_pkg::*;

  // Zero wait states
  a_pready_high: assert property (@(posedge clock) disable iff (reset) pready)
    else $error("pready low");

  // Errors only in the access phase
  a_pslverr_access: assert property (@(posedge clock) disable iff (reset)
    pslverr |-> (psel && penable))
    else $error("pslverr outside an access phase");

  // Unstable needs a prior aligned cycle
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
    a_unstable_after_aligned: assert property (@(posedge clock) disable iff (reset)
      $rose(unstable[c]) |-> $past(aligned[c]))
      else $error("unstable rose on channel %0d without prior alignment", c);
  end

  // Outputs quiet once reset has been sampled
  a_reset_quiet: assert property (@(posedge clock)
    $past(reset) |-> ((aligned == '0) && (sbits_out == '0)))
    else $error("aligned or sbits_out nonzero during reset");

endmodule

bind sbit_align_top sbit_align_props u_props (
  .clock     (clock),
  .reset     (reset),
  .psel      (psel),
  .penable   (penable),
  .pready    (pready),
  .pslverr   (pslverr),
  .aligned   (aligned),
  .unstable  (unstable),
  .sbits_out (sbits_out)
);

/* testbench/sbit_align_tb.sv */
// S-bit aligner testbench: APB setup, SoF and random data stimulus, reference slip model
`timescale 1ns/1ps
module sbit_align_tb;

  import sbit_align_pkg::*;

  localparam int CLK_PERIOD       = 40;
  localparam int RESET_CYCLES     = 10;
  localparam int DRIVE_DELAY      = 2;
  // Upper bound on the cycles the sequence below spends
  localparam int STIM_CYCLES      = 400;
  localparam int TEST_READY_COUNT = 6;
  localparam int ALIGN_MARGIN     = 4;
  localparam int ALIGN_TIMEOUT    = 64;

  logic                                 clock;
  logic                                 reset;
  logic                                 psel;
  logic                                 penable;
  logic                                 pwrite;
  logic [APB_ADDR_WIDTH-1:0]            paddr;
  logic [APB_DATA_WIDTH-1:0]            pwdata;
  logic [APB_DATA_WIDTH-1:0]            prdata;
  logic                                 pready;
  logic                                 pslverr;
  logic [NUM_CHANNELS*MXSBITS-1:0]      sbits_in;
  logic [NUM_CHANNELS*FRAME_SIZE-1:0]   start_of_frame;
  logic [NUM_CHANNELS*MXSBITS-1:0]      sbits_out;
  logic [NUM_CHANNELS-1:0]              aligned;

  integer seed;
  int     error_count;
  int     check_count;
  // SoF pattern driven on each channel every frame
  logic [FRAME_SIZE-1:0]   sof_cfg [NUM_CHANNELS];
  // Expected CTRL contents, updated as a write enters its access phase
  logic [NUM_CHANNELS-1:0] mask_shadow;
  logic                    soft_pending;

  // Reference model state, one entry per channel
  logic [MXSBITS-1:0]      prev_frame [NUM_CHANNELS];
  logic [SLIP_WIDTH-1:0]   slip_model [NUM_CHANNELS];
  logic [FRAME_SIZE-1:0]   sof_model  [NUM_CHANNELS];
  logic [NUM_CHANNELS-1:0] aligned_prev;
  logic [NUM_CHANNELS-1:0] mask_prev;
  logic                    soft_prev;

  sbit_align_top dut0 (
    .clock          (clock),
    .reset          (reset),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .sbits_in       (sbits_in),
    .start_of_frame (start_of_frame),
    .sbits_out      (sbits_out),
    .aligned        (aligned)
  );

  initial begin : clock_gen
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // ------------------------------
  // Reference functions
  // ------------------------------

  // One-hot at p means slip (p+1) mod 8, anything else slip 1
  function automatic logic [SLIP_WIDTH-1:0] sof_to_slip(input logic [FRAME_SIZE-1:0] sof);
    logic [SLIP_WIDTH-1:0] slip;
    slip = SLIP_WIDTH'(1);
    if ($countones(sof) == 1) begin
      for (int p = 0; p < FRAME_SIZE; p++) begin
        if (sof[p]) begin
          slip = SLIP_WIDTH'((p + 1) % FRAME_SIZE);
        end
      end
    end
    return slip;
  endfunction

  // Per lane, bits [n+7:n] of {current, previous}
  function automatic logic [MXSBITS-1:0] slip_reference(input logic [MXSBITS-1:0] cur,
                                                        input logic [MXSBITS-1:0] prev,
                                                        input logic [SLIP_WIDTH-1:0] slip);
    logic [MXSBITS-1:0]      result;
    logic [2*FRAME_SIZE-1:0] shifted;
    result = '0;
    for (int lane = 0; lane < LANES; lane++) begin
      shifted = {cur[lane*FRAME_SIZE +: FRAME_SIZE], prev[lane*FRAME_SIZE +: FRAME_SIZE]} >> slip;
      result[lane*FRAME_SIZE +: FRAME_SIZE] = shifted[FRAME_SIZE-1:0];
    end
    return result;
  endfunction

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // ------------------------------
  // Stimulus tasks
  // ------------------------------

  task automatic drive_frames();
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      for (int w = 0; w < MXSBITS / 32; w++) begin
        sbits_in[c*MXSBITS + w*32 +: 32] = $random(seed);
      end
      start_of_frame[c*FRAME_SIZE +: FRAME_SIZE] = sof_cfg[c];
    end
  endtask

  // New frame shortly after every rising edge
  task automatic next_cycle();
    @(posedge clock);
    #DRIVE_DELAY;
    drive_frames();
  endtask

  task automatic run_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr,
                           input logic [APB_DATA_WIDTH-1:0] data, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    next_cycle();
    penable = 1'b1;
    // CTRL takes the new value at the coming edge
    if (addr == ADDR_CTRL) begin
      mask_shadow = data[NUM_CHANNELS-1:0];
      soft_pending = data[SOFT_RESET_BIT];
    end
    @(negedge clock);
    err = pslverr;
    check_equal(64'(pready), 64'(1'b1), "pready in write access");
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] addr,
                          output logic [APB_DATA_WIDTH-1:0] data, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    next_cycle();
    penable = 1'b1;
    // Mid access phase, prdata settled
    @(negedge clock);
    data = prdata;
    err  = pslverr;
    check_equal(64'(pready), 64'(1'b1), "pready in read access");
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_expect(input logic [APB_ADDR_WIDTH-1:0] addr,
                              input logic [APB_DATA_WIDTH-1:0] data,
                              input logic expected_err, input string what);
    logic err;
    apb_write(addr, data, err);
    check_equal(64'(err), 64'(expected_err), {what, " pslverr"});
  endtask

  task automatic read_expect(input logic [APB_ADDR_WIDTH-1:0] addr,
                             input logic [APB_DATA_WIDTH-1:0] expected, input string what);
    logic [APB_DATA_WIDTH-1:0] data;
    logic                      err;
    apb_read(addr, data, err);
    check_equal(64'(err), 64'(1'b0), {what, " pslverr"});
    check_equal(64'(data), 64'(expected), what);
  endtask

  task automatic wait_all_aligned(input string what);
    int waited;
    waited = 0;
    while (aligned !== {NUM_CHANNELS{1'b1}} && waited < ALIGN_TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (aligned !== {NUM_CHANNELS{1'b1}}) begin
      error_count++;
      $display("Channels never all aligned within %0d cycles %s", ALIGN_TIMEOUT, what);
    end
  endtask

  // ------------------------------
  // Output comparator
  // ------------------------------

  // At 1 ns past each edge, predict what that edge produced
  initial begin : compare_outputs
    logic               chan_rst;
    logic               lane_rst;
    logic [MXSBITS-1:0] cur_in;
    logic [MXSBITS-1:0] expected;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      prev_frame[c] = '0;
      slip_model[c] = SLIP_WIDTH'(1);
      sof_model[c]  = '0;
    end
    aligned_prev = '0;
    mask_prev    = '0;
    soft_prev    = 1'b0;
    forever begin
      @(posedge clock);
      #1;
      chan_rst = reset | soft_prev;
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        // Lanes held clear unless enabled and aligned
        lane_rst = chan_rst | mask_prev[c] | ~aligned_prev[c];
        cur_in   = sbits_in[c*MXSBITS +: MXSBITS];
        expected = lane_rst ? '0 : slip_reference(cur_in, prev_frame[c], slip_model[c]);
        check_equal(sbits_out[c*MXSBITS +: MXSBITS], expected,
                    $sformatf("channel %0d sbits_out", c));
        prev_frame[c] = lane_rst ? '0 : cur_in;
        slip_model[c] = chan_rst ? SLIP_WIDTH'(1) : sof_to_slip(sof_model[c]);
        sof_model[c]  = start_of_frame[c*FRAME_SIZE +: FRAME_SIZE];
      end
      // Register values seen by the next edge
      aligned_prev = aligned;
      mask_prev    = mask_shadow;
      soft_prev    = soft_pending;
      soft_pending = 1'b0;
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin : main_sequence
    seed         = 32'h4dcc66c8;
    error_count  = 0;
    check_count  = 0;
    reset        = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    mask_shadow  = '0;
    soft_pending = 1'b0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      sof_cfg[c] = '0;
    end
    drive_frames();
    run_cycles(RESET_CYCLES);
    reset = 1'b0;

    // Reset values
    check_equal(64'(aligned), 64'(0), "aligned after reset");
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      check_equal(sbits_out[c*MXSBITS +: MXSBITS], 64'(0), "sbits_out after reset");
    end
    read_expect(ADDR_CTRL, 32'h0, "CTRL reset value");
    read_expect(ADDR_READY_COUNT, 32'(READY_COUNT_RESET), "READY_COUNT reset value");
    read_expect(ADDR_STATUS, 32'h0, "STATUS reset value");

    // Register access and error responses
    write_expect(ADDR_READY_COUNT, 32'hffff_f123, 1'b0, "READY_COUNT write");
    read_expect(ADDR_READY_COUNT, 32'h0000_0123, "READY_COUNT readback");
    write_expect(ADDR_CTRL, 32'h0000_0105, 1'b0, "CTRL write with soft reset");
    read_expect(ADDR_CTRL, 32'h0000_0005, "CTRL readback");
    write_expect(ADDR_CTRL, 32'h0, 1'b0, "CTRL clear");
    begin : unmapped_read
      logic [APB_DATA_WIDTH-1:0] data;
      logic                      err;
      apb_read(8'h10, data, err);
      check_equal(64'(err), 64'(1'b1), "pslverr on unmapped read");
    end
    write_expect(ADDR_STATUS, 32'h0, 1'b1, "STATUS write");
    write_expect(ADDR_READY_COUNT, 32'(TEST_READY_COUNT), 1'b0, "small READY_COUNT");

    // Constant SoF at a different phase per channel
    sof_cfg[0] = 8'h02;
    sof_cfg[1] = 8'h08;
    sof_cfg[2] = 8'h40;
    sof_cfg[3] = 8'h80;
    run_cycles(TEST_READY_COUNT + 4 + ALIGN_MARGIN);
    check_equal(64'(aligned), 64'(4'hf), "aligned after stable period");
    read_expect(ADDR_STATUS, 32'h0000_000f, "STATUS all aligned");
    run_cycles(40);

    // Mask channel 1 and release it
    write_expect(ADDR_CTRL, 32'h0000_0002, 1'b0, "mask channel 1");
    run_cycles(3);
    check_equal(sbits_out[MXSBITS +: MXSBITS], 64'(0), "masked channel 1 output");
    check_equal(64'(aligned), 64'(4'hf), "aligned while masked");
    run_cycles(20);
    write_expect(ADDR_CTRL, 32'h0, 1'b0, "unmask channel 1");
    run_cycles(20);

    // Single bad SoF on channel 2
    sof_cfg[2] = 8'h18;
    next_cycle();
    sof_cfg[2] = 8'h40;
    run_cycles(3);
    check_equal(64'(aligned), 64'(4'b1011), "aligned after SoF glitch");
    read_expect(ADDR_STATUS, 32'h0000_040b, "STATUS after SoF glitch");
    wait_all_aligned("after SoF glitch");
    read_expect(ADDR_STATUS, 32'h0000_040f, "STATUS realigned, still unstable");

    // Soft reset clears the sticky flag
    write_expect(ADDR_CTRL, 32'h0000_0100, 1'b0, "soft reset");
    next_cycle();
    check_equal(64'(aligned), 64'(0), "aligned after soft reset");
    read_expect(ADDR_STATUS, 32'h0, "STATUS after soft reset");
    wait_all_aligned("after soft reset");
    read_expect(ADDR_STATUS, 32'h0000_000f, "STATUS realigned after soft reset");
    read_expect(ADDR_CTRL, 32'h0, "CTRL soft reset bit reads zero");
    run_cycles(20);

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    #((STIM_CYCLES + 500) * CLK_PERIOD);
    $display("Timeout, the sequence did not finish within %0d cycles", STIM_CYCLES + 500);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* verilog.f */
src/sbit_align_pkg.sv
src/frame_bitslip.sv
src/frame_aligner.sv
src/align_apb_regs.sv
src/sbit_align_top.sv
testbench/sbit_align_props.sv
testbench/sbit_align_tb.sv
